/* common/ciPkg.sv */
`default_nettype none

package ciPkg;

  // instruction number and operand sizes.
  parameter int ciNumberWidth = 8;
  parameter int ciDataWidth = 32;

  // instruction numbers used when the top level does not override them.
  parameter logic [ciNumberWidth-1:0] defaultSwapByteId = 8'd1;
  parameter logic [ciNumberWidth-1:0] defaultGrayscaleId = 8'd13;

  // operation selected by the decode stage.
  typedef enum logic [1:0] {
    ciOpNone = 2'd0, // unknown number, completes with zero.
    ciOpSwap = 2'd1,
    ciOpGray = 2'd2
  } ciOp;

endpackage

`default_nettype wire

/* common/pixelPkg.sv */
`default_nettype none

package pixelPkg;

  typedef struct packed {
    logic [7:0] high;
    logic [7:0] low;
  } pixelBytes;

  // red sits in the top bits of the word.
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } pixelColour;

  // one 16-bit word, seen as two bytes or as colour fields.
  typedef union packed {
    pixelBytes bytes;
    pixelColour colour;
  } rgb565Pixel;

  // luminance weights, scaled so that they sum to 256.
  parameter logic [7:0] grayRedWeight = 8'd54;
  parameter logic [7:0] grayGreenWeight = 8'd183;
  parameter logic [7:0] grayBlueWeight = 8'd19;

  parameter int grayWidth = 8;

endpackage

`default_nettype wire

/* design/resetSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module resetSequencer #(
  parameter int resetCycles = 16
) (
  input  wire logic s_systemClock,
  input  wire logic s_pllLocked,
  output logic      sequencerDone
);

  localparam int countWidth = $clog2(resetCycles + 1);
  localparam logic [countWidth-1:0] countLimit = countWidth'(resetCycles);

  logic [countWidth-1:0] s_resetCountReg;

  // held at zero while the PLL is unlocked, stops once the limit is reached.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_resetCountReg <= '0;
    end else if (s_resetCountReg != countLimit) begin
      s_resetCountReg <= s_resetCountReg + 1'b1;
    end
  end

  assign sequencerDone = (s_resetCountReg == countLimit); // stays high after the count.

endmodule

`default_nettype wire

/* ciPipeline/rgb565Grayscale.sv */
`timescale 1ns/10ps
`default_nettype none

module rgb565Grayscale (
  input  wire pixelPkg::rgb565Pixel           pixel,
  output logic [pixelPkg::grayWidth-1:0]      gray
);

  logic [7:0]  s_red;
  logic [7:0]  s_green;
  logic [7:0]  s_blue;
  logic [15:0] s_weightedSum;

  // scale each field up to 8 bits.
  assign s_red   = {pixel.colour.red, 3'b000};
  assign s_green = {pixel.colour.green, 2'b00};
  assign s_blue  = {pixel.colour.blue, 3'b000};

  // weights sum to 256, so the top byte is the gray level.
  assign s_weightedSum = s_red * pixelPkg::grayRedWeight +
                         s_green * pixelPkg::grayGreenWeight +
                         s_blue * pixelPkg::grayBlueWeight;

  assign gray = s_weightedSum[15:8];

endmodule

`default_nettype wire

/* ciPipeline/ciDecodeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module ciDecodeStage #(
  parameter logic [ciPkg::ciNumberWidth-1:0] swapByteId = ciPkg::defaultSwapByteId,
  parameter logic [ciPkg::ciNumberWidth-1:0] grayscaleId = ciPkg::defaultGrayscaleId
) (
  input  wire logic                           s_systemClock,
  input  wire logic                           s_pllLocked,
  input  wire logic                           sequencerDone,
  input  wire logic                           ciValid,
  output logic                                ciReady,
  input  wire logic [ciPkg::ciNumberWidth-1:0] ciNumber,
  input  wire logic [ciPkg::ciDataWidth-1:0]   ciDataA,
  input  wire logic [ciPkg::ciDataWidth-1:0]   ciDataB,
  output logic                                decodeValid,
  input  wire logic                           executeReady,
  output ciPkg::ciOp                          decodeOp,
  output logic [ciPkg::ciDataWidth-1:0]        decodeDataA,
  output logic [ciPkg::ciDataWidth-1:0]        decodeDataB
);

  ciPkg::ciOp s_nextOp;
  logic       s_accept;

  // the only comparison against the configured instruction numbers.
  always_comb begin
    if (ciNumber == swapByteId) begin
      s_nextOp = ciPkg::ciOpSwap;
    end else if (ciNumber == grayscaleId) begin
      s_nextOp = ciPkg::ciOpGray;
    end else begin
      s_nextOp = ciPkg::ciOpNone;
    end
  end

  // room when empty or when the execute stage takes the current entry.
  assign ciReady  = sequencerDone & (~decodeValid | executeReady);
  assign s_accept = ciValid & ciReady;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      decodeValid <= 1'b0;
    end else if (ciReady) begin
      decodeValid <= ciValid; // empties when nothing new arrives.
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (s_accept) begin
      decodeOp    <= s_nextOp;
      decodeDataA <= ciDataA;
      decodeDataB <= ciDataB;
    end
  end

endmodule

`default_nettype wire

/* ciPipeline/ciExecuteStage.sv */
`timescale 1ns/10ps
`default_nettype none

module ciExecuteStage (
  input  wire logic                         s_systemClock,
  input  wire logic                         s_pllLocked,
  input  wire logic                         decodeValid,
  output logic                              executeReady,
  input  wire ciPkg::ciOp                   decodeOp,
  input  wire logic [ciPkg::ciDataWidth-1:0] decodeDataA,
  input  wire logic [ciPkg::ciDataWidth-1:0] decodeDataB,
  output logic                              resultValid,
  input  wire logic                         resultReady,
  output logic [ciPkg::ciDataWidth-1:0]      result
);

  localparam int grayPad = ciPkg::ciDataWidth - pixelPkg::grayWidth;

  pixelPkg::rgb565Pixel          s_upperHalf;
  pixelPkg::rgb565Pixel          s_lowerHalf;
  logic [pixelPkg::grayWidth-1:0] s_grayValue;
  logic [ciPkg::ciDataWidth-1:0]  s_swapResult;
  logic [ciPkg::ciDataWidth-1:0]  s_nextResult;
  logic                           s_load;

  assign s_upperHalf = decodeDataA[31:16];
  assign s_lowerHalf = decodeDataA[15:0]; // also the pixel operand.

  rgb565Grayscale converter (
    .pixel(s_lowerHalf),
    .gray(s_grayValue)
  );

  // bit 0 of operand B picks halfword swap over full reversal.
  always_comb begin
    if (decodeDataB[0]) begin
      s_swapResult = {s_upperHalf.bytes.low, s_upperHalf.bytes.high,
                      s_lowerHalf.bytes.low, s_lowerHalf.bytes.high};
    end else begin
      s_swapResult = {s_lowerHalf.bytes.low, s_lowerHalf.bytes.high,
                      s_upperHalf.bytes.low, s_upperHalf.bytes.high};
    end
  end

  always_comb begin
    case (decodeOp)
      ciPkg::ciOpSwap: s_nextResult = s_swapResult;
      ciPkg::ciOpGray: s_nextResult = {{grayPad{1'b0}}, s_grayValue};
      default:         s_nextResult = '0; // unknown numbers return zero.
    endcase
  end

  assign executeReady = ~resultValid | resultReady;
  assign s_load       = decodeValid & executeReady;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resultValid <= 1'b0;
    end else if (executeReady) begin
      resultValid <= decodeValid;
    end
  end

  // held until the requester takes it.
  always_ff @(posedge s_systemClock) begin
    if (s_load) begin
      result <= s_nextResult;
    end
  end

endmodule

`default_nettype wire

/* design/ciCoprocessor.sv */
`timescale 1ns/10ps
`default_nettype none

module ciCoprocessor #(
  parameter logic [ciPkg::ciNumberWidth-1:0] swapByteId = ciPkg::defaultSwapByteId,
  parameter logic [ciPkg::ciNumberWidth-1:0] grayscaleId = ciPkg::defaultGrayscaleId,
  parameter int resetCycles = 16
) (
  input  wire logic                           s_systemClock,
  input  wire logic                           s_pllLocked,
  input  wire logic                           ciValid,
  output logic                                ciReady,
  input  wire logic [ciPkg::ciNumberWidth-1:0] ciNumber,
  input  wire logic [ciPkg::ciDataWidth-1:0]   ciDataA,
  input  wire logic [ciPkg::ciDataWidth-1:0]   ciDataB,
  output logic                                resultValid,
  input  wire logic                           resultReady,
  output logic [ciPkg::ciDataWidth-1:0]        result
);

  logic                          sequencerDone;
  logic                          decodeValid;
  logic                          executeReady;
  ciPkg::ciOp                    decodeOp;
  logic [ciPkg::ciDataWidth-1:0] decodeDataA;
  logic [ciPkg::ciDataWidth-1:0] decodeDataB;

  resetSequencer #(.resetCycles(resetCycles)) sequencer (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .sequencerDone(sequencerDone)
  );

  ciDecodeStage #(
    .swapByteId(swapByteId),
    .grayscaleId(grayscaleId)
  ) decode (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .sequencerDone(sequencerDone),
    .ciValid(ciValid),
    .ciReady(ciReady),
    .ciNumber(ciNumber),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .decodeValid(decodeValid),
    .executeReady(executeReady),
    .decodeOp(decodeOp),
    .decodeDataA(decodeDataA),
    .decodeDataB(decodeDataB)
  );

  ciExecuteStage execute (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .decodeValid(decodeValid),
    .executeReady(executeReady),
    .decodeOp(decodeOp),
    .decodeDataA(decodeDataA),
    .decodeDataB(decodeDataB),
    .resultValid(resultValid),
    .resultReady(resultReady),
    .result(result)
  );

endmodule

`default_nettype wire

/* testbench/ciCoprocessorTb.sv */
`timescale 1ns/10ps
`default_nettype none

module ciCoprocessorTb;

  localparam int swapCount = 16;
  localparam int grayCount = 12;
  localparam int unknownCount = 12;
  localparam int pressureCount = 30;
  localparam int streamCount = 20;
  localparam int plannedTransactions = swapCount + 10 + 2 * grayCount + unknownCount +
                                       3 + pressureCount + streamCount;
  // 20 cycles per transaction, plus reset, sequencer and spare cycles.
  localparam int watchdogNs = (plannedTransactions * 20 + 16 + 16 + 20) * 8;
  localparam logic [15:0] cornerPixels [5] = '{16'h0000, 16'hffff, 16'hf800, 16'h07e0,
                                               16'h001f};

  logic        s_systemClock = 1'b0;
  logic        s_pllLocked;
  logic        ciValid;
  logic        ciReady;
  logic [7:0]  ciNumber;
  logic [31:0] ciDataA;
  logic [31:0] ciDataB;
  logic        resultValid;
  logic        resultReady;
  logic [31:0] result;

  logic [31:0] rngState = 32'd54;
  int          readyMode = 0; // 0 always ready, 1 never ready, 2 random.
  bit          latencyMode = 1'b0;
  bit          pipelineOpen = 1'b0;
  logic [31:0] expectQ[$];
  int          acceptQ[$];
  int          cycleCount = 0;
  bit          holdPending = 1'b0;
  logic [31:0] heldResult;
  int          monitorErrors = 0;
  int          mainErrors = 0;
  int          assertErrors = 0;
  int          testStartErrors = 0;
  int          testsPassed = 0;
  int          testsFailed = 0;

  ciCoprocessor UUT (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ciValid(ciValid),
    .ciReady(ciReady),
    .ciNumber(ciNumber),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .resultValid(resultValid),
    .resultReady(resultReady),
    .result(result)
  );

  always #4 s_systemClock = ~s_systemClock;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] randomWord();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  // anything but the swap and gray numbers.
  function automatic logic [7:0] unknownNumber(input logic [7:0] n);
    if (n == 8'd1 || n == 8'd13) begin
      return n + 8'd2;
    end
    return n;
  endfunction

  function automatic logic [31:0] modelResult(input logic [7:0] number, input logic [31:0] a,
                                              input logic [31:0] b);
    logic [31:0] sum;
    if (number == 8'd1) begin
      if (b[0]) begin
        return {a[23:16], a[31:24], a[7:0], a[15:8]};
      end
      return {a[7:0], a[15:8], a[23:16], a[31:24]};
    end
    if (number == 8'd13) begin
      sum = 32'({a[15:11], 3'b000}) * 32'd54 + 32'({a[10:5], 2'b00}) * 32'd183 +
            32'({a[4:0], 3'b000}) * 32'd19;
      return {24'd0, sum[15:8]};
    end
    return 32'd0;
  endfunction

  task automatic checkLevel(input string name, input logic expected, input logic actual);
    assert (actual === expected) else begin
      $display("[ERROR] %0t %s expected %b got %b", $time, name, expected, actual);
      mainErrors++;
    end
  endtask

  // one clock, then the result side for the next cycle.
  task automatic stepCycle();
    logic [31:0] r;
    @(posedge s_systemClock);
    #1;
    r = randomWord();
    case (readyMode)
      0: resultReady = 1'b1;
      1: resultReady = 1'b0;
      default: resultReady = r[7];
    endcase
  endtask

  task automatic sendInstruction(input logic [7:0] number, input logic [31:0] a,
                                 input logic [31:0] b, output int waits);
    bit taken;
    waits = 0;
    ciValid = 1'b1;
    ciNumber = number;
    ciDataA = a;
    ciDataB = b;
    do begin
      @(negedge s_systemClock);
      taken = ciReady;
      waits++;
      stepCycle();
    end while (!taken);
  endtask

  task automatic sendMix(input int count, input bit expectNoWait);
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [7:0]  number;
    int          waits;
    for (int i = 0; i < count; i++) begin
      r = randomWord();
      a = randomWord();
      b = randomWord();
      case (r % 32'd3)
        0: number = 8'd1;
        1: number = 8'd13;
        default: number = unknownNumber(r[15:8]);
      endcase
      sendInstruction(number, a, b, waits);
      if (expectNoWait) begin
        assert (waits == 1) else begin
          $display("instruction %0d waited %0d cycles for ciReady while streaming", i, waits);
          mainErrors++;
        end
      end
    end
  endtask

  // empty the pipeline with the result side always ready.
  task automatic drainPipeline();
    int guard;
    ciValid = 1'b0;
    readyMode = 0;
    guard = 0;
    while (expectQ.size() != 0 && guard < 40) begin
      stepCycle();
      guard++;
    end
    assert (expectQ.size() == 0) else begin
      $display("%0d results never arrived after the inputs stopped", expectQ.size());
      mainErrors++;
    end
  endtask

  task automatic finishTest(input string name);
    int errors;
    errors = mainErrors + monitorErrors + assertErrors - testStartErrors;
    $display("test %s: %s, %0d errors", name, errors == 0 ? "ok" : "failed", errors);
    if (errors == 0) begin
      testsPassed++;
    end else begin
      testsFailed++;
    end
    testStartErrors = mainErrors + monitorErrors + assertErrors;
  endtask

  // a held result keeps its valid until the requester takes it.
  holdValid: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
                              resultValid && !resultReady |=> resultValid)
    else begin
      $display("resultValid dropped at %0t before its result was taken", $time);
      assertErrors++;
    end

  // samples at the falling edge, describing the next rising edge.
  always @(negedge s_systemClock) begin
    logic [31:0] expected;
    int          accepted;
    cycleCount++;
    if (pipelineOpen) begin
      assert (ciReady == (expectQ.size() < 2 || resultReady)) else begin
        $display("[ERROR] %0t ciReady expected %b got %b", $time,
                 expectQ.size() < 2 || resultReady, ciReady);
        monitorErrors++;
      end
    end
    if (holdPending) begin
      assert (resultValid && result === heldResult) else begin
        $display("[ERROR] %0t result expected %h got %h while held", $time, heldResult, result);
        monitorErrors++;
      end
    end
    holdPending = resultValid && !resultReady;
    heldResult = result;
    if (resultValid && resultReady) begin
      assert (expectQ.size() != 0) else begin
        $display("a result was delivered at %0t with no instruction outstanding", $time);
        monitorErrors++;
      end
      if (expectQ.size() != 0) begin
        expected = expectQ.pop_front();
        accepted = acceptQ.pop_front();
        assert (result === expected) else begin
          $display("[ERROR] %0t result expected %h got %h", $time, expected, result);
          monitorErrors++;
        end
        if (latencyMode) begin
          assert (cycleCount - accepted == 2) else begin
            $display("result at %0t arrived %0d cycles after acceptance instead of 2", $time,
                     cycleCount - accepted);
            monitorErrors++;
          end
        end
      end
    end
    if (ciValid && ciReady) begin
      expectQ.push_back(modelResult(ciNumber, ciDataA, ciDataB));
      acceptQ.push_back(cycleCount);
    end
  end

  initial begin
    int          waits;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    s_pllLocked = 1'b0;
    ciValid = 1'b0;
    ciNumber = 8'd0;
    ciDataA = 32'd0;
    ciDataB = 32'd0;
    resultReady = 1'b0;

    repeat (16) begin
      @(negedge s_systemClock);
      checkLevel("ciReady", 1'b0, ciReady);
      checkLevel("resultValid", 1'b0, resultValid);
    end
    @(posedge s_systemClock);
    #1;
    s_pllLocked = 1'b1;
    repeat (16) begin
      @(negedge s_systemClock);
      checkLevel("ciReady", 1'b0, ciReady);
      checkLevel("resultValid", 1'b0, resultValid);
    end
    @(negedge s_systemClock);
    checkLevel("ciReady", 1'b1, ciReady);
    checkLevel("resultValid", 1'b0, resultValid);
    stepCycle();
    pipelineOpen = 1'b1;
    finishTest("reset");

    for (int i = 0; i < swapCount; i++) begin
      a = randomWord();
      r = randomWord();
      b = {r[31:1], i[0]}; // alternate reversal and halfword swap.
      sendInstruction(8'd1, a, b, waits);
    end
    drainPipeline();
    finishTest("byte swap");

    for (int i = 0; i < 5; i++) begin
      r = randomWord();
      sendInstruction(8'd13, {16'h0000, cornerPixels[i]}, r, waits);
      sendInstruction(8'd13, {r[31:16], cornerPixels[i]}, r, waits);
    end
    for (int i = 0; i < grayCount; i++) begin
      a = randomWord();
      b = randomWord();
      sendInstruction(8'd13, a, b, waits);
      sendInstruction(8'd13, {~a[31:16], a[15:0]}, b, waits); // other upper half.
    end
    drainPipeline();
    finishTest("grayscale");

    for (int i = 0; i < unknownCount; i++) begin
      r = randomWord();
      a = randomWord();
      b = randomWord();
      sendInstruction(unknownNumber(r[7:0]), a, b, waits);
    end
    drainPipeline();
    finishTest("unknown instruction");

    readyMode = 1;
    stepCycle();
    sendMix(2, 1'b0);
    a = randomWord();
    b = randomWord();
    ciValid = 1'b1;
    ciNumber = 8'd1;
    ciDataA = a;
    ciDataB = b;
    repeat (6) stepCycle();
    checkLevel("ciReady", 1'b0, ciReady); // both stages hold an entry.
    readyMode = 2;
    sendInstruction(8'd1, a, b, waits);
    sendMix(pressureCount, 1'b0);
    drainPipeline();
    finishTest("back-pressure");

    latencyMode = 1'b1;
    stepCycle();
    sendMix(streamCount, 1'b1);
    drainPipeline();
    latencyMode = 1'b0;
    finishTest("throughput and latency");

    $display("tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
    if (testsFailed == 0 && mainErrors + monitorErrors + assertErrors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdogNs);
    $display("watchdog expired after %0d ns, the run did not finish", watchdogNs);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
common/ciPkg.sv
common/pixelPkg.sv
design/resetSequencer.sv
ciPipeline/rgb565Grayscale.sv
ciPipeline/ciDecodeStage.sv
ciPipeline/ciExecuteStage.sv
design/ciCoprocessor.sv
testbench/ciCoprocessorTb.sv

/* runSim.sh */
#!/bin/sh
# builds the coprocessor testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -Mdir "$buildDir" --top-module ciCoprocessorTb -f all.f
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

"./$buildDir/VciCoprocessorTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$logFile"; then
  echo "failure reported in $logFile"
  exit 1
fi

exit 0
